// ==== control_unit.f ====
+incdir+hdl
hdl/control_unit_pkg.sv
hdl/alu_op_decoder.sv
hdl/mem_op_decoder.sv
hdl/control_decoder.sv
hdl/id_control_stage.sv
hdl/control_unit.sv
testbench/control_unit_sva.sv
testbench/control_unit_tb.sv

// ==== hdl/alu_op_decoder.sv ====
`timescale 1ns/10ps
`include "control_unit_defines.svh"

module alu_op_decoder (
    input  logic [`CU_OP3_HI-`CU_OP3_LO:0] op3,
    output control_unit_pkg::alu_op_e      alu_op,
    output logic                           cc_enable,
    output logic                           known
);

    import control_unit_pkg::*;

    arith_op3_e code;

    assign code = arith_op3_e'(op3);

    // ALU operation per op3, cc and non-cc variants share the operation
    always_comb begin
        alu_op = ALU_ADD;
        known  = 1'b1;
        case (code)
            OP3_ADD, OP3_ADDCC:   alu_op = ALU_ADD;
            OP3_ADDX, OP3_ADDXCC: alu_op = ALU_ADDX;
            OP3_SUB, OP3_SUBCC:   alu_op = ALU_SUB;
            OP3_SUBX:             alu_op = ALU_SUBX;
            OP3_AND, OP3_ANDCC:   alu_op = ALU_AND;
            OP3_ANDN, OP3_ANDNCC: alu_op = ALU_ANDN;
            OP3_OR, OP3_ORCC:     alu_op = ALU_OR;
            OP3_ORN, OP3_ORNCC:   alu_op = ALU_ORN;
            OP3_XOR, OP3_XORCC:   alu_op = ALU_XOR;
            OP3_XNOR, OP3_XNORCC: alu_op = ALU_XNOR;
            OP3_SLL:              alu_op = ALU_SLL;
            OP3_SRL:              alu_op = ALU_SRL;
            OP3_SRA:              alu_op = ALU_SRA;
            default: begin
                known = 1'b0;   // Not in the table
            end
        endcase
    end

    // Condition code update only for the cc variants
    always_comb begin
        case (code)
            OP3_ADDCC,
            OP3_ADDXCC,
            OP3_SUBCC,
            OP3_ANDCC,
            OP3_ANDNCC,
            OP3_ORCC,
            OP3_ORNCC,
            OP3_XORCC,
            OP3_XNORCC: cc_enable = 1'b1;
            default:    cc_enable = 1'b0;
        endcase
    end

endmodule

// ==== hdl/control_decoder.sv ====
`timescale 1ns/10ps
`include "control_unit_defines.svh"

module control_decoder (
    input  logic [`CU_INSTR_W-1:0]       instr,
    output logic                         jmpl,
    output logic                         call,
    output logic                         branch,
    output logic                         load,
    output logic                         rf_enable,
    output logic                         mem_se,
    output logic                         mem_rw,
    output logic                         mem_enable,
    output control_unit_pkg::mem_size_e  mem_size,
    output control_unit_pkg::alu_op_e    alu_op,
    output logic                         cc_enable
);

    import control_unit_pkg::*;

    instr_fmt_e                          fmt;
    logic [`CU_OP2_HI-`CU_OP2_LO:0]      op2;
    logic [`CU_OP3_HI-`CU_OP3_LO:0]      op3;
    logic                                is_nop;

    alu_op_e                             tbl_alu_op;
    logic                                tbl_cc_enable;
    logic                                alu_known;
    mem_size_e                           tbl_mem_size;
    logic                                tbl_mem_se;
    logic                                tbl_mem_rw;
    logic                                tbl_load;
    logic                                mem_known;

    assign fmt    = instr_fmt_e'(instr[`CU_OP_HI:`CU_OP_LO]);
    assign op2    = instr[`CU_OP2_HI:`CU_OP2_LO];
    assign op3    = instr[`CU_OP3_HI:`CU_OP3_LO];
    assign is_nop = (instr == '0);

    alu_op_decoder u_alu_op_decoder (
        .op3       (op3),
        .alu_op    (tbl_alu_op),
        .cc_enable (tbl_cc_enable),
        .known     (alu_known)
    );

    mem_op_decoder u_mem_op_decoder (
        .op3      (op3),
        .mem_size (tbl_mem_size),
        .mem_se   (tbl_mem_se),
        .mem_rw   (tbl_mem_rw),
        .load     (tbl_load),
        .known    (mem_known)
    );

    always_comb begin
        // Everything off unless a rule below turns it on
        jmpl       = 1'b0;
        call       = 1'b0;
        branch     = 1'b0;
        load       = 1'b0;
        rf_enable  = 1'b0;
        mem_se     = 1'b0;
        mem_rw     = 1'b0;
        mem_enable = 1'b0;
        mem_size   = SIZE_BYTE;
        alu_op     = ALU_ADD;
        cc_enable  = 1'b0;
        if (!is_nop) begin
            case (fmt)
                FMT_BR_SETHI: begin
                    if (op2 == `CU_OP2_SETHI) begin
                        alu_op = ALU_PASS_B;    // Operand B carries the immediate
                    end else if (op2 == `CU_OP2_BRANCH) begin
                        branch = 1'b1;
                    end
                end
                FMT_CALL: begin
                    call      = 1'b1;
                    rf_enable = 1'b1;   // Return address to r15
                end
                FMT_ARITH: begin
                    if (op3 == `CU_OP3_JMPL) begin
                        jmpl = 1'b1;
                    end else if (op3 == `CU_OP3_SAVE || op3 == `CU_OP3_RESTORE) begin
                        rf_enable  = 1'b1;
                        mem_enable = 1'b1;
                        mem_size   = SIZE_WORD;
                    end else if (alu_known) begin
                        alu_op    = tbl_alu_op;
                        cc_enable = tbl_cc_enable;
                    end
                end
                FMT_MEM: begin
                    if (mem_known) begin
                        load       = tbl_load;
                        rf_enable  = tbl_load;  // Only loads write back
                        mem_enable = 1'b1;
                        mem_se     = tbl_mem_se;
                        mem_rw     = tbl_mem_rw;
                        mem_size   = tbl_mem_size;
                    end
                end
                default: ;
            endcase
        end
    end

endmodule

// ==== hdl/control_unit.sv ====
`timescale 1ns/10ps
`include "control_unit_defines.svh"

module control_unit (
    input  logic                         clk,
    input  logic                         clr,
    input  logic [`CU_INSTR_W-1:0]       instr,
    input  logic                         bubble,
    output logic                         jmpl,
    output logic                         call,
    output logic                         branch,
    output logic                         load,
    output logic                         rf_enable,
    output logic                         mem_se,
    output logic                         mem_rw,
    output logic                         mem_enable,
    output control_unit_pkg::mem_size_e  mem_size,
    output logic                         i31,
    output logic                         i30,
    output logic                         i24,
    output logic                         i13,
    output control_unit_pkg::alu_op_e    alu_op,
    output logic                         cc_enable
);

    import control_unit_pkg::*;

    // Decoded values ahead of the stage register
    logic       next_jmpl, next_call, next_branch, next_load, next_rf_enable;
    logic       next_mem_se, next_mem_rw, next_mem_enable, next_cc_enable;
    mem_size_e  next_mem_size;
    alu_op_e    next_alu_op;

    control_decoder u_control_decoder (
        .instr      (instr),
        .jmpl       (next_jmpl),
        .call       (next_call),
        .branch     (next_branch),
        .load       (next_load),
        .rf_enable  (next_rf_enable),
        .mem_se     (next_mem_se),
        .mem_rw     (next_mem_rw),
        .mem_enable (next_mem_enable),
        .mem_size   (next_mem_size),
        .alu_op     (next_alu_op),
        .cc_enable  (next_cc_enable)
    );

    id_control_stage u_id_control_stage (
        .clk             (clk),
        .clr             (clr),
        .bubble          (bubble),
        .instr           (instr),
        .next_jmpl       (next_jmpl),
        .next_call       (next_call),
        .next_branch     (next_branch),
        .next_load       (next_load),
        .next_rf_enable  (next_rf_enable),
        .next_mem_se     (next_mem_se),
        .next_mem_rw     (next_mem_rw),
        .next_mem_enable (next_mem_enable),
        .next_mem_size   (next_mem_size),
        .next_alu_op     (next_alu_op),
        .next_cc_enable  (next_cc_enable),
        .jmpl            (jmpl),
        .call            (call),
        .branch          (branch),
        .load            (load),
        .rf_enable       (rf_enable),
        .mem_se          (mem_se),
        .mem_rw          (mem_rw),
        .mem_enable      (mem_enable),
        .mem_size        (mem_size),
        .i31             (i31),
        .i30             (i30),
        .i24             (i24),
        .i13             (i13),
        .alu_op          (alu_op),
        .cc_enable       (cc_enable)
    );

endmodule

// ==== hdl/control_unit_defines.svh ====
`ifndef CONTROL_UNIT_DEFINES_SVH
`define CONTROL_UNIT_DEFINES_SVH

// Instruction word
`define CU_INSTR_W 32

// Format field, selects one of the four SPARC formats
`define CU_OP_HI 31
`define CU_OP_LO 30

// op2 field of format 0
`define CU_OP2_HI 24
`define CU_OP2_LO 22

// op3 field of formats 2 and 3
`define CU_OP3_HI 24
`define CU_OP3_LO 19

// Format 0 op2 codes
`define CU_OP2_SETHI  3'd4
`define CU_OP2_BRANCH 3'd2

// Format 2 op3 codes handled outside the arithmetic table
`define CU_OP3_JMPL    6'b111000
`define CU_OP3_SAVE    6'b111100
`define CU_OP3_RESTORE 6'b111101

`endif

// ==== hdl/control_unit_pkg.sv ====
package control_unit_pkg;

    // Instruction format, from bits 31:30
    typedef enum logic [1:0] {
        FMT_BR_SETHI = 2'd0,
        FMT_CALL     = 2'd1,
        FMT_ARITH    = 2'd2,
        FMT_MEM      = 2'd3
    } instr_fmt_e;

    // ALU operation codes as the execute stage expects them
    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_ADDX   = 4'd1,
        ALU_SUB    = 4'd2,
        ALU_SUBX   = 4'd3,
        ALU_AND    = 4'd4,
        ALU_OR     = 4'd5,
        ALU_XOR    = 4'd6,
        ALU_XNOR   = 4'd7,
        ALU_ANDN   = 4'd8,
        ALU_ORN    = 4'd9,
        ALU_SLL    = 4'd10,
        ALU_SRL    = 4'd11,
        ALU_SRA    = 4'd12,
        ALU_PASS_B = 4'd14  // Forward operand B, used by SETHI
    } alu_op_e;

    // Data memory access size
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } mem_size_e;

    // Format 2 arithmetic, logic and shift op3 codes
    typedef enum logic [5:0] {
        OP3_ADD    = 6'b000000,
        OP3_ADDCC  = 6'b010000,
        OP3_ADDX   = 6'b001000,
        OP3_ADDXCC = 6'b011000,
        OP3_SUB    = 6'b000100,
        OP3_SUBCC  = 6'b010100,
        OP3_SUBX   = 6'b001100,
        OP3_AND    = 6'b000001,
        OP3_ANDCC  = 6'b010001,
        OP3_ANDN   = 6'b000101,
        OP3_ANDNCC = 6'b010101,
        OP3_OR     = 6'b000010,
        OP3_ORCC   = 6'b010010,
        OP3_ORN    = 6'b000110,
        OP3_ORNCC  = 6'b010110,
        OP3_XOR    = 6'b000011,
        OP3_XORCC  = 6'b010011,
        OP3_XNOR   = 6'b000111,
        OP3_XNORCC = 6'b010111,
        OP3_SLL    = 6'b100101,
        OP3_SRL    = 6'b100110,
        OP3_SRA    = 6'b100111
    } arith_op3_e;

    // Format 3 load/store op3 codes
    typedef enum logic [5:0] {
        MEM_LDSB = 6'b001001,
        MEM_LDSH = 6'b001010,
        MEM_LD   = 6'b000000,
        MEM_LDUB = 6'b000001,
        MEM_LDUH = 6'b000010,
        MEM_STB  = 6'b000101,
        MEM_STH  = 6'b000110,
        MEM_ST   = 6'b000100
    } mem_op3_e;

endpackage

// ==== hdl/id_control_stage.sv ====
`timescale 1ns/10ps
`include "control_unit_defines.svh"

module id_control_stage (
    input  logic                         clk,
    input  logic                         clr,
    input  logic                         bubble,
    input  logic [`CU_INSTR_W-1:0]       instr,
    input  logic                         next_jmpl,
    input  logic                         next_call,
    input  logic                         next_branch,
    input  logic                         next_load,
    input  logic                         next_rf_enable,
    input  logic                         next_mem_se,
    input  logic                         next_mem_rw,
    input  logic                         next_mem_enable,
    input  control_unit_pkg::mem_size_e  next_mem_size,
    input  control_unit_pkg::alu_op_e    next_alu_op,
    input  logic                         next_cc_enable,
    output logic                         jmpl,
    output logic                         call,
    output logic                         branch,
    output logic                         load,
    output logic                         rf_enable,
    output logic                         mem_se,
    output logic                         mem_rw,
    output logic                         mem_enable,
    output control_unit_pkg::mem_size_e  mem_size,
    output logic                         i31,
    output logic                         i30,
    output logic                         i24,
    output logic                         i13,
    output control_unit_pkg::alu_op_e    alu_op,
    output logic                         cc_enable
);

    import control_unit_pkg::*;

    logic       jmpl_r, call_r, branch_r, load_r, rf_enable_r;
    logic       mem_se_r, mem_rw_r, mem_enable_r, cc_enable_r;
    logic       i31_r, i30_r, i24_r, i13_r;
    mem_size_e  mem_size_r;
    alu_op_e    alu_op_r;

    always_ff @(posedge clk or negedge clr) begin
        if (!clr) begin
            jmpl_r       <= 1'b0;
            call_r       <= 1'b0;
            branch_r     <= 1'b0;
            load_r       <= 1'b0;
            rf_enable_r  <= 1'b0;
            mem_se_r     <= 1'b0;
            mem_rw_r     <= 1'b0;
            mem_enable_r <= 1'b0;
            mem_size_r   <= SIZE_BYTE;
            alu_op_r     <= ALU_ADD;
            cc_enable_r  <= 1'b0;
            i31_r        <= 1'b0;
            i30_r        <= 1'b0;
            i24_r        <= 1'b0;
            i13_r        <= 1'b0;
        end else begin
            // Keeps loading while bubble is high
            jmpl_r       <= next_jmpl;
            call_r       <= next_call;
            branch_r     <= next_branch;
            load_r       <= next_load;
            rf_enable_r  <= next_rf_enable;
            mem_se_r     <= next_mem_se;
            mem_rw_r     <= next_mem_rw;
            mem_enable_r <= next_mem_enable;
            mem_size_r   <= next_mem_size;
            alu_op_r     <= next_alu_op;
            cc_enable_r  <= next_cc_enable;
            i31_r        <= instr[31];
            i30_r        <= instr[30];
            i24_r        <= instr[24];
            i13_r        <= instr[13];
        end
    end

    // Bubble mux, zeroes the stage output in the same cycle
    assign jmpl       = bubble ? 1'b0 : jmpl_r;
    assign call       = bubble ? 1'b0 : call_r;
    assign branch     = bubble ? 1'b0 : branch_r;
    assign load       = bubble ? 1'b0 : load_r;
    assign rf_enable  = bubble ? 1'b0 : rf_enable_r;
    assign mem_se     = bubble ? 1'b0 : mem_se_r;
    assign mem_rw     = bubble ? 1'b0 : mem_rw_r;
    assign mem_enable = bubble ? 1'b0 : mem_enable_r;
    assign mem_size   = bubble ? SIZE_BYTE : mem_size_r;
    assign alu_op     = bubble ? ALU_ADD : alu_op_r;
    assign cc_enable  = bubble ? 1'b0 : cc_enable_r;
    assign i31        = bubble ? 1'b0 : i31_r;
    assign i30        = bubble ? 1'b0 : i30_r;
    assign i24        = bubble ? 1'b0 : i24_r;
    assign i13        = bubble ? 1'b0 : i13_r;

endmodule

// ==== hdl/mem_op_decoder.sv ====
`timescale 1ns/10ps
`include "control_unit_defines.svh"

module mem_op_decoder (
    input  logic [`CU_OP3_HI-`CU_OP3_LO:0] op3,
    output control_unit_pkg::mem_size_e    mem_size,
    output logic                           mem_se,
    output logic                           mem_rw,  // 1 for stores
    output logic                           load,
    output logic                           known
);

    import control_unit_pkg::*;

    mem_op3_e code;

    assign code = mem_op3_e'(op3);

    always_comb begin
        mem_size = SIZE_BYTE;
        mem_se   = 1'b0;
        mem_rw   = 1'b0;
        load     = 1'b0;
        known    = 1'b1;
        case (code)
            // Loads, signed ones need sign extension
            MEM_LDSB: begin
                load   = 1'b1;
                mem_se = 1'b1;
            end
            MEM_LDSH: begin
                load     = 1'b1;
                mem_se   = 1'b1;
                mem_size = SIZE_HALF;
            end
            MEM_LD: begin
                load     = 1'b1;
                mem_size = SIZE_WORD;
            end
            MEM_LDUB: load = 1'b1;
            MEM_LDUH: begin
                load     = 1'b1;
                mem_size = SIZE_HALF;
            end
            // Stores
            MEM_STB: mem_rw = 1'b1;
            MEM_STH: begin
                mem_rw   = 1'b1;
                mem_size = SIZE_HALF;
            end
            MEM_ST: begin
                mem_rw   = 1'b1;
                mem_size = SIZE_WORD;
            end
            default: known = 1'b0;
        endcase
    end

endmodule

// ==== testbench/control_unit_sva.sv ====
`timescale 1ns/10ps

module control_unit_sva (
    input  logic                         clk,
    input  logic                         clr,
    input  logic                         bubble,
    input  logic                         jmpl,
    input  logic                         call,
    input  logic                         branch,
    input  logic                         load,
    input  logic                         rf_enable,
    input  logic                         mem_se,
    input  logic                         mem_rw,
    input  logic                         mem_enable,
    input  control_unit_pkg::mem_size_e  mem_size,
    input  logic                         i31,
    input  logic                         i30,
    input  logic                         i24,
    input  logic                         i13,
    input  control_unit_pkg::alu_op_e    alu_op,
    input  logic                         cc_enable
);

    import control_unit_pkg::*;

    int   fail_count = 0;   // Read by the testbench at the end
    logic any_out;

    // High when any output differs from its zero value
    assign any_out = jmpl | call | branch | load | rf_enable | mem_se | mem_rw | mem_enable
                   | (mem_size != SIZE_BYTE) | (alu_op != ALU_ADD) | cc_enable
                   | i31 | i30 | i24 | i13;

    bubble_zero: assert property (@(posedge clk) disable iff (!clr) bubble |-> !any_out)
        else begin
            fail_count++;
            $error("outputs not zero while bubble is high");
        end

    // A store always comes with a memory access
    rw_needs_enable: assert property (@(posedge clk) disable iff (!clr) mem_rw |-> mem_enable)
        else begin
            fail_count++;
            $error("mem_rw high without mem_enable");
        end

    one_transfer: assert property (@(posedge clk) disable iff (!clr)
                                   $onehot0({jmpl, call, branch, load}))
        else begin
            fail_count++;
            $error("more than one of jmpl, call, branch, load high");
        end

    zero_after_reset: assert property (@(posedge clk) $rose(clr) |-> !any_out)
        else begin
            fail_count++;
            $error("outputs not zero when clr is released");
        end

endmodule

bind control_unit control_unit_sva sva_check (.*);

// ==== testbench/control_unit_tb.sv ====
`timescale 1ns/10ps

module control_unit_tb;

    import control_unit_pkg::*;

    // Tests run about 115 cycles
    localparam int CYCLE_LIMIT = 400;

    logic        clk;
    logic        clr;
    logic        bubble;
    logic [31:0] instr;
    logic        jmpl, call, branch, load, rf_enable;
    logic        mem_se, mem_rw, mem_enable, cc_enable;
    logic        i31, i30, i24, i13;
    mem_size_e   mem_size;
    alu_op_e     alu_op;

    int errors = 0;
    int cycles = 0;

    // Arithmetic table, op3 code with its ALU operation and cc flag
    arith_op3_e arith_code [22] = '{OP3_ADD, OP3_ADDCC, OP3_ADDX, OP3_ADDXCC, OP3_SUB,
        OP3_SUBCC, OP3_SUBX, OP3_AND, OP3_ANDCC, OP3_ANDN, OP3_ANDNCC, OP3_OR, OP3_ORCC,
        OP3_ORN, OP3_ORNCC, OP3_XOR, OP3_XORCC, OP3_XNOR, OP3_XNORCC, OP3_SLL, OP3_SRL, OP3_SRA};
    alu_op_e arith_alu [22] = '{ALU_ADD, ALU_ADD, ALU_ADDX, ALU_ADDX, ALU_SUB,
        ALU_SUB, ALU_SUBX, ALU_AND, ALU_AND, ALU_ANDN, ALU_ANDN, ALU_OR, ALU_OR,
        ALU_ORN, ALU_ORN, ALU_XOR, ALU_XOR, ALU_XNOR, ALU_XNOR, ALU_SLL, ALU_SRL, ALU_SRA};
    logic arith_cc [22] = '{0, 1, 0, 1, 0, 1, 0, 0, 1, 0, 1, 0, 1, 0, 1, 0, 1, 0, 1, 0, 0, 0};

    // Memory table
    mem_op3_e  mem_code [8] = '{MEM_LDSB, MEM_LDSH, MEM_LD, MEM_LDUB, MEM_LDUH,
                                MEM_STB, MEM_STH, MEM_ST};
    mem_size_e mem_sz [8]   = '{SIZE_BYTE, SIZE_HALF, SIZE_WORD, SIZE_BYTE, SIZE_HALF,
                                SIZE_BYTE, SIZE_HALF, SIZE_WORD};
    logic mem_sgn [8]  = '{1, 1, 0, 0, 0, 0, 0, 0};
    logic mem_st [8]   = '{0, 0, 0, 0, 0, 1, 1, 1};
    logic mem_ld [8]   = '{1, 1, 1, 1, 1, 0, 0, 0};

    control_unit UUT (.*);

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run stopped after %0d cycles", cycles);
            $display("Done: errors found");
            $finish;
        end
    end

    task automatic next_cycle;
        @(posedge clk);
        #2;
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s is %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_alu_op(input string name, input alu_op_e got, input alu_op_e exp);
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s is %0d, expected %s", $time, name, got, exp.name());
        end
    endtask

    task automatic check_size(input string name, input mem_size_e got, input mem_size_e exp);
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s is %0d, expected %s", $time, name, got, exp.name());
        end
    endtask

    task automatic check_controls(
        input logic      e_jmpl,
        input logic      e_call,
        input logic      e_branch,
        input logic      e_load,
        input logic      e_rf,
        input logic      e_se,
        input logic      e_rw,
        input logic      e_men,
        input mem_size_e e_size,
        input alu_op_e   e_alu,
        input logic      e_cc
    );
        check_bit("jmpl", jmpl, e_jmpl);
        check_bit("call", call, e_call);
        check_bit("branch", branch, e_branch);
        check_bit("load", load, e_load);
        check_bit("rf_enable", rf_enable, e_rf);
        check_bit("mem_se", mem_se, e_se);
        check_bit("mem_rw", mem_rw, e_rw);
        check_bit("mem_enable", mem_enable, e_men);
        check_size("mem_size", mem_size, e_size);
        check_alu_op("alu_op", alu_op, e_alu);
        check_bit("cc_enable", cc_enable, e_cc);
    endtask

    // Raw bits copied from the registered word
    task automatic check_raw(input logic [31:0] w);
        check_bit("i31", i31, w[31]);
        check_bit("i30", i30, w[30]);
        check_bit("i24", i24, w[24]);
        check_bit("i13", i13, w[13]);
    endtask

    task automatic check_zero;
        check_controls(0, 0, 0, 0, 0, 0, 0, 0, SIZE_BYTE, ALU_ADD, 0);
        check_raw(32'h0);
    endtask

    // Drive a word, then wait until its decode is stable on the outputs
    task automatic issue(input logic [31:0] w);
        next_cycle;
        instr = w;
        next_cycle;
        #28;
    endtask

    function automatic logic [31:0] op3_word(input logic [1:0] fmt, input logic [5:0] op3);
        logic [31:0] w;
        w = $urandom;
        w[31:30] = fmt;
        w[24:19] = op3;
        return w;
    endfunction

    task automatic reset_and_nop;
        logic [31:0] w;
        #28;
        check_zero;
        issue(32'h0);
        check_zero;
        w = op3_word(2'b00, {3'b110, 3'($urandom)});   // op2 neither SETHI nor branch
        issue(w);
        check_controls(0, 0, 0, 0, 0, 0, 0, 0, SIZE_BYTE, ALU_ADD, 0);
        check_raw(w);
    endtask

    task automatic arith_table;
        logic [31:0] w;
        for (int i = 0; i < 22; i++) begin
            w = op3_word(2'b10, arith_code[i]);
            issue(w);
            check_controls(0, 0, 0, 0, 0, 0, 0, 0, SIZE_BYTE, arith_alu[i], arith_cc[i]);
            check_raw(w);
        end
        w = op3_word(2'b10, 6'b101010);   // Not in any table
        issue(w);
        check_controls(0, 0, 0, 0, 0, 0, 0, 0, SIZE_BYTE, ALU_ADD, 0);
    endtask

    task automatic mem_table;
        logic [31:0] w;
        for (int i = 0; i < 8; i++) begin
            w = op3_word(2'b11, mem_code[i]);
            issue(w);
            check_controls(0, 0, 0, mem_ld[i], mem_ld[i], mem_sgn[i], mem_st[i], 1,
                           mem_sz[i], ALU_ADD, 0);
            check_raw(w);
        end
        issue(op3_word(2'b11, 6'b111111));
        check_controls(0, 0, 0, 0, 0, 0, 0, 0, SIZE_BYTE, ALU_ADD, 0);
    endtask

    task automatic control_transfer;
        issue(op3_word(2'b01, 6'($urandom)));   // call
        check_controls(0, 1, 0, 0, 1, 0, 0, 0, SIZE_BYTE, ALU_ADD, 0);
        issue(op3_word(2'b10, 6'b111000));      // jmpl
        check_controls(1, 0, 0, 0, 0, 0, 0, 0, SIZE_BYTE, ALU_ADD, 0);
        issue(op3_word(2'b00, {3'b010, 3'($urandom)}));
        check_controls(0, 0, 1, 0, 0, 0, 0, 0, SIZE_BYTE, ALU_ADD, 0);
        issue(op3_word(2'b00, {3'b100, 3'($urandom)}));  // SETHI
        check_controls(0, 0, 0, 0, 0, 0, 0, 0, SIZE_BYTE, ALU_PASS_B, 0);
        issue(op3_word(2'b10, 6'b111100));      // save
        check_controls(0, 0, 0, 0, 1, 0, 0, 1, SIZE_WORD, ALU_ADD, 0);
        issue(op3_word(2'b10, 6'b111101));      // restore
        check_controls(0, 0, 0, 0, 1, 0, 0, 1, SIZE_WORD, ALU_ADD, 0);
    endtask

    task automatic bubble_hold;
        logic [31:0] w;
        issue(op3_word(2'b11, MEM_LDSH));
        check_controls(0, 0, 0, 1, 1, 1, 0, 1, SIZE_HALF, ALU_ADD, 0);
        next_cycle;
        w = op3_word(2'b11, MEM_ST);
        bubble = 1'b1;
        instr = w;      // Registered under the bubble
        #28;
        check_zero;
        next_cycle;
        bubble = 1'b0;
        #28;
        check_controls(0, 0, 0, 0, 0, 0, 1, 1, SIZE_WORD, ALU_ADD, 0);
        check_raw(w);
    endtask

    task automatic back_to_back;
        logic [31:0] w;
        logic [31:0] held;
        int          idx;
        int          held_idx;
        next_cycle;
        idx = $urandom_range(21);
        w = op3_word(2'b10, arith_code[idx]);
        instr = w;
        repeat (20) begin
            held = w;
            held_idx = idx;
            next_cycle;
            idx = $urandom_range(21);
            w = op3_word(2'b10, arith_code[idx]);
            instr = w;
            #28;
            check_controls(0, 0, 0, 0, 0, 0, 0, 0, SIZE_BYTE,
                           arith_alu[held_idx], arith_cc[held_idx]);
            check_raw(held);
        end
        next_cycle;
        instr = 32'h0;
        #28;
        check_controls(0, 0, 0, 0, 0, 0, 0, 0, SIZE_BYTE, arith_alu[idx], arith_cc[idx]);
        check_raw(w);
    endtask

    initial begin
        clk = 1'b0;
        clr = 1'b0;
        bubble = 1'b0;
        instr = 32'h0;
        void'($urandom(32'h7b93));
        repeat (4) @(posedge clk);
        #2;
        clr = 1'b1;
        reset_and_nop;
        arith_table;
        mem_table;
        control_transfer;
        bubble_hold;
        back_to_back;
        next_cycle;
        $display("errors: %0d check mismatches, %0d assertion failures",
                 errors, UUT.sva_check.fail_count);
        if (errors == 0 && UUT.sva_check.fail_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule
